// ==== filelist.f ====
+incdir+rtl
rtl/ooo_exec_pkg.sv
rtl/unit_result_if.sv
rtl/arith_unit.sv
rtl/branch_jump_unit.sv
rtl/multiply_unit.sv
rtl/result_queue.sv
rtl/ooo_execute_stage.sv
verif/ooo_execute_checker.sv
verif/tb_ooo_execute_stage.sv

// ==== verif/tb_ooo_execute_stage.sv ====
/*
  Execute stage testbench
  Directed tests for ALU, branch, jump and multiply results, result
  ordering, credit back-pressure and flush, checked against a
  reference model of the stage's rules
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module tb_ooo_execute_stage;
  import ooo_exec_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int XLEN = `OOO_XLEN;
  // Operations issued over all tests
  localparam int TOTAL_OPS = 74;
  localparam int WATCHDOG_NS = TOTAL_OPS * `OOO_MUL_STEPS * CLK_PERIOD + 2000;
  localparam int WAIT_LIMIT = 4 * `OOO_MUL_STEPS;

  typedef struct packed {
    logic wen;
    reg_idx_t rd;
    word_t wdata;
    logic redirect;
    word_t target;
    logic is_brj;
  } expect_t;

  logic CLK;
  logic nRST;
  logic flush;
  logic issue_valid;
  unit_sel_t issue_unit;
  alu_op_t alu_op;
  br_type_t br_type;
  word_t port_a;
  word_t port_b;
  word_t imm;
  word_t pc;
  reg_idx_t rd;
  logic prediction;
  logic issue_ready;
  logic res_valid;
  reg_idx_t res_rd;
  logic res_wen;
  word_t res_wdata;
  logic res_redirect;
  word_t res_target;
  logic credit_return;

  expect_t exp_q[$];
  int value_errors;
  int proto_errors;
  int owed_credits;
  int sent_count;
  logic hold_credits;

  ooo_execute_stage i_ooo_execute_stage (
    .CLK(CLK),
    .nRST(nRST),
    .flush(flush),
    .issue_valid(issue_valid),
    .issue_unit(issue_unit),
    .alu_op(alu_op),
    .br_type(br_type),
    .port_a(port_a),
    .port_b(port_b),
    .imm(imm),
    .pc(pc),
    .rd(rd),
    .prediction(prediction),
    .issue_ready(issue_ready),
    .res_valid(res_valid),
    .res_rd(res_rd),
    .res_wen(res_wen),
    .res_wdata(res_wdata),
    .res_redirect(res_redirect),
    .res_target(res_target),
    .credit_return(credit_return)
  );

  bind ooo_execute_stage ooo_execute_checker i_ooo_execute_checker (
    .CLK(CLK),
    .nRST(nRST),
    .flush(flush),
    .issue_valid(issue_valid),
    .issue_ready(issue_ready),
    .issue_unit(issue_unit),
    .mul_busy(mul_busy),
    .res_valid(res_valid),
    .credit_cnt(i_result_queue.credit_cnt),
    .count(i_result_queue.count),
    .mul_push(i_result_queue.mul_push),
    .unit_push(i_result_queue.unit_push),
    .pop(i_result_queue.pop)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Reference ALU
  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    int sh;
    logic [2*XLEN-1:0] ext;
    sh = b % XLEN;
    ext = {{XLEN{a[XLEN-1]}}, a};
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 1;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return word_t'(ext >> sh);
      // Differing signs make the negative operand smaller
      ALU_SLT:  return (a[XLEN-1] != b[XLEN-1]) ? word_t'(a[XLEN-1]) : word_t'(a < b);
      default:  return word_t'(a < b);
    endcase
  endfunction

  function automatic logic branch_model(input br_type_t bt, input word_t a, input word_t b);
    logic lt_u;
    logic lt_s;
    lt_u = (a < b);
    lt_s = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : lt_u;
    case (bt)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return lt_s;
      BR_BGE:  return !lt_s;
      BR_BLTU: return lt_u;
      BR_BGEU: return !lt_u;
      default: return 1'b1;
    endcase
  endfunction

  task automatic report_value(input string name, input word_t got, input word_t want);
    $display("** Error: %s got %h expected %h at %0t", name, got, want, $time);
    value_errors++;
  endtask

  task automatic check_result(input expect_t e);
    assert (res_rd == e.rd) else report_value("res_rd", res_rd, e.rd);
    assert (res_wen == e.wen) else report_value("res_wen", res_wen, e.wen);
    assert (res_redirect == e.redirect) else report_value("res_redirect", res_redirect, e.redirect);
    // ALU and multiply results carry their value even when x0 is the target
    if (e.wen || !e.is_brj) begin
      assert (res_wdata == e.wdata) else report_value("res_wdata", res_wdata, e.wdata);
    end
    if (e.is_brj) begin
      assert (res_target == e.target) else report_value("res_target", res_target, e.target);
    end
  endtask

  // Commit side checks each result and hands its credit back
  always @(negedge CLK) begin : commit_side
    expect_t e;
    if (nRST && res_valid) begin
      sent_count++;
      owed_credits++;
      assert (exp_q.size() != 0) else begin
        $display("Unexpected result for x%0d at %0t, none was outstanding", res_rd, $time);
        proto_errors++;
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        check_result(e);
      end
    end
    if (!hold_credits && owed_credits > 0) begin
      credit_return = 1'b1;
      owed_credits--;
    end else begin
      credit_return = 1'b0;
    end
  end

  // Offer one operation and hold it until accepted
  task automatic issue_op(input unit_sel_t unit, input alu_op_t op, input br_type_t bt,
      input word_t a, input word_t b, input word_t im, input word_t p, input reg_idx_t r,
      input logic pred);
    int waited;
    waited = 0;
    @(negedge CLK);
    issue_valid = 1'b1;
    issue_unit = unit;
    alu_op = op;
    br_type = bt;
    port_a = a;
    port_b = b;
    imm = im;
    pc = p;
    rd = r;
    prediction = pred;
    #(CLK_PERIOD / 4);
    while (!issue_ready) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("Operation for x%0d was never accepted, issue_ready stayed low", r);
        proto_errors++;
        issue_valid = 1'b0;
        return;
      end
      @(negedge CLK);
      #(CLK_PERIOD / 4);
    end
  endtask

  task automatic idle();
    @(negedge CLK);
    issue_valid = 1'b0;
    issue_unit = NONE;
  endtask

  task automatic issue_alu(input alu_op_t op, input word_t a, input word_t b,
      input reg_idx_t r, input logic keep);
    expect_t e;
    issue_op(ALU, op, BR_BEQ, a, b, '0, '0, r, 1'b0);
    e = '{wen: (r != '0), rd: r, wdata: alu_model(op, a, b), redirect: 1'b0,
          target: '0, is_brj: 1'b0};
    if (keep) begin
      exp_q.push_back(e);
    end
  endtask

  task automatic issue_brj(input br_type_t bt, input word_t a, input word_t b, input word_t im,
      input word_t p, input reg_idx_t r, input logic pred);
    expect_t e;
    logic taken;
    logic jump;
    taken = branch_model(bt, a, b);
    jump = (bt == BR_JAL) || (bt == BR_JALR);
    issue_op(BRJ, ALU_ADD, bt, a, b, im, p, r, pred);
    e.wen = jump && (r != '0);
    e.rd = r;
    e.wdata = p + 4;
    e.redirect = pred ^ taken;
    e.is_brj = 1'b1;
    if (!taken) begin
      e.target = p + 4;
    end else if (bt == BR_JALR) begin
      e.target = a + im;
      e.target[0] = 1'b0;
    end else begin
      e.target = p + im;
    end
    exp_q.push_back(e);
  endtask

  task automatic issue_mul(input word_t a, input word_t b, input reg_idx_t r);
    issue_op(MUL, ALU_ADD, BR_BEQ, a, b, '0, '0, r, 1'b0);
  endtask

  // Pushed when the product enters the queue rather than at issue
  task automatic expect_mul(input word_t a, input word_t b, input reg_idx_t r);
    logic [2*XLEN-1:0] product;
    product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
    exp_q.push_back('{wen: (r != '0), rd: r, wdata: product[XLEN-1:0], redirect: 1'b0,
                      target: '0, is_brj: 1'b0});
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge CLK);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results never reached commit", exp_q.size());
      proto_errors++;
      exp_q.delete();
    end
    // Let outstanding credits come home
    repeat (4) @(posedge CLK);
  endtask

  task automatic test_alu();
    for (int i = 0; i < 10; i++) begin
      issue_alu(alu_op_t'(i), $urandom(), $urandom(), (i == 2) ? reg_idx_t'(0) :
                reg_idx_t'(i + 1), 1'b1);
    end
    idle();
    wait_drain();
  endtask

  task automatic test_branches();
    word_t pair_a [3];
    word_t pair_b [3];
    int k;
    pair_a = '{32'd5, 32'd5, 32'hFFFF_FFFD};
    pair_b = '{32'd5, 32'd7, 32'd2};
    k = 0;
    for (int t = 0; t < 6; t++) begin
      for (int j = 0; j < 3; j++) begin
        for (int pr = 0; pr < 2; pr++) begin
          issue_brj(br_type_t'(t), pair_a[j], pair_b[j], $urandom() & 32'h0000_0FFC,
                    32'h0000_1000 + 4 * k, reg_idx_t'(j + 1), pr[0]);
          k++;
        end
      end
    end
    idle();
    wait_drain();
  endtask

  task automatic test_jumps();
    issue_brj(BR_JAL, $urandom(), $urandom(), 32'h0000_0100, 32'h0000_2000, 5'd1, 1'b1);
    issue_brj(BR_JAL, $urandom(), $urandom(), 32'hFFFF_FFF0, 32'h0000_2004, 5'd0, 1'b0);
    // Odd sum needs bit 0 cleared
    issue_brj(BR_JALR, 32'h0000_3001, '0, 32'h0000_0010, 32'h0000_2008, 5'd2, 1'b1);
    issue_brj(BR_JALR, $urandom(), $urandom(), $urandom(), 32'h0000_200C, 5'd3, 1'b0);
    idle();
    wait_drain();
  endtask

  task automatic test_mul_order();
    word_t a1;
    word_t b1;
    word_t a3;
    word_t b3;
    a1 = $urandom();
    b1 = $urandom();
    a3 = $urandom();
    b3 = $urandom();
    issue_mul(a1, b1, 5'd7);
    for (int i = 0; i < 4; i++) begin
      issue_alu(ALU_ADD, $urandom(), $urandom(), reg_idx_t'(8 + i), 1'b1);
    end
    expect_mul(a1, b1, 5'd7);
    // Offered while busy and held until the first product is done
    issue_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd12);
    expect_mul(32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd12);
    idle();
    wait_drain();
    // ALU result lands in the same cycle as the product
    issue_mul(a3, b3, 5'd13);
    expect_mul(a3, b3, 5'd13);
    idle();
    repeat (`OOO_MUL_STEPS - 1) @(negedge CLK);
    issue_alu(ALU_SUB, $urandom(), $urandom(), 5'd14, 1'b1);
    idle();
    wait_drain();
  endtask

  task automatic test_backpressure();
    int base;
    @(posedge CLK);
    hold_credits = 1'b1;
    base = sent_count;
    for (int i = 0; i < 7; i++) begin
      issue_alu(ALU_XOR, $urandom(), $urandom(), reg_idx_t'(16 + i), 1'b1);
    end
    idle();
    repeat (10) @(negedge CLK);
    #(CLK_PERIOD / 4);
    assert (sent_count - base == `OOO_CREDITS) else begin
      $display("%0d results sent with %0d credits", sent_count - base, `OOO_CREDITS);
      proto_errors++;
    end
    assert (!issue_ready) else begin
      $display("issue_ready stayed high with the result queue full");
      proto_errors++;
    end
    @(posedge CLK);
    hold_credits = 1'b0;
    wait_drain();
  endtask

  task automatic test_flush();
    word_t a;
    word_t b;
    a = $urandom();
    b = $urandom();
    @(posedge CLK);
    hold_credits = 1'b1;
    issue_mul($urandom(), $urandom(), 5'd20);
    // Only the results sent before the flush survive
    for (int i = 0; i < 6; i++) begin
      issue_alu(ALU_OR, $urandom(), $urandom(), reg_idx_t'(21 + i), i < `OOO_CREDITS);
    end
    idle();
    @(negedge CLK);
    flush = 1'b1;
    @(negedge CLK);
    flush = 1'b0;
    @(posedge CLK);
    hold_credits = 1'b0;
    repeat (`OOO_MUL_STEPS + 8) @(negedge CLK);
    wait_drain();
    issue_mul(a, b, 5'd27);
    issue_alu(ALU_ADD, $urandom(), $urandom(), 5'd28, 1'b1);
    expect_mul(a, b, 5'd27);
    idle();
    wait_drain();
  endtask

  initial begin
    void'($urandom(65631));
    nRST = 1'b0;
    flush = 1'b0;
    issue_valid = 1'b0;
    issue_unit = NONE;
    alu_op = ALU_ADD;
    br_type = BR_BEQ;
    port_a = '0;
    port_b = '0;
    imm = '0;
    pc = '0;
    rd = '0;
    prediction = 1'b0;
    credit_return = 1'b0;
    hold_credits = 1'b0;
    owed_credits = 0;
    sent_count = 0;
    value_errors = 0;
    proto_errors = 0;
    repeat (2) @(negedge CLK);
    nRST = 1'b1;
    test_alu();
    test_branches();
    test_jumps();
    test_mul_order();
    test_backpressure();
    test_flush();
    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run stopped after %0d ns without finishing", WATCHDOG_NS);
    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== verif/ooo_execute_checker.sv ====
/*
  Execute stage protocol checker
  Concurrent rules on credit use, multiply issue and result queue
  occupancy, bound into the execute stage
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module ooo_execute_checker (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic issue_valid,
  input logic issue_ready,
  input ooo_exec_pkg::unit_sel_t issue_unit,
  input logic mul_busy,
  input logic res_valid,
  input ooo_exec_pkg::credit_t credit_cnt,
  input logic [$clog2(`OOO_RQ_DEPTH+1)-1:0] count,
  input logic mul_push,
  input logic unit_push,
  input logic pop
);
  import ooo_exec_pkg::*;

  logic mul_fire;

  assign mul_fire = issue_valid && issue_ready && (issue_unit == MUL);

  // Every send spends a credit held in the cycle before
  credit_held: assert property (@(posedge CLK) disable iff (!nRST)
    res_valid |-> ($past(credit_cnt) != '0))
    else $error("result sent to commit with no credit held");

  // Busy spans the whole multiply and no second MUL enters it
  mul_not_busy: assert property (@(posedge CLK) disable iff (!nRST || flush)
    mul_fire |=> (mul_busy && !mul_fire) [*`OOO_MUL_STEPS + 1])
    else $error("multiply accepted while the multiplier was busy");

  // Pushes never exceed the space left after this cycle's send
  no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
    !flush |-> (32'(count) + 32'(mul_push) + 32'(unit_push) <= `OOO_RQ_DEPTH + 32'(pop)))
    else $error("result pushed into a full result queue");

endmodule

// ==== rtl/ooo_execute_stage.sv ====
/*
  Out-of-order execute stage
  ALU, branch/jump and iterative multiply units feeding an in-order
  result queue that sends to commit under credit flow control
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module ooo_execute_stage (
  input logic CLK,
  input logic nRST,
  input logic flush,
  // Issue from dispatch
  input logic issue_valid,
  input ooo_exec_pkg::unit_sel_t issue_unit,
  input ooo_exec_pkg::alu_op_t alu_op,
  input ooo_exec_pkg::br_type_t br_type,
  input ooo_exec_pkg::word_t port_a,
  input ooo_exec_pkg::word_t port_b,
  input ooo_exec_pkg::word_t imm,
  input ooo_exec_pkg::word_t pc,
  input ooo_exec_pkg::reg_idx_t rd,
  input logic prediction,
  output logic issue_ready,
  // Results to commit
  output logic res_valid,
  output ooo_exec_pkg::reg_idx_t res_rd,
  output logic res_wen,
  output ooo_exec_pkg::word_t res_wdata,
  output logic res_redirect,
  output ooo_exec_pkg::word_t res_target,
  input logic credit_return
);
  import ooo_exec_pkg::*;

  logic issue_fire;
  logic mul_start;
  logic mul_busy;

  unit_result_if alu_res();
  unit_result_if brj_res();
  unit_result_if mul_res();

  arith_unit i_arith_unit (
    .issue_valid(issue_fire),
    .issue_unit(issue_unit),
    .alu_op(alu_op),
    .port_a(port_a),
    .port_b(port_b),
    .rd(rd),
    .res(alu_res.unit)
  );

  branch_jump_unit i_branch_jump_unit (
    .issue_valid(issue_fire),
    .issue_unit(issue_unit),
    .br_type(br_type),
    .port_a(port_a),
    .port_b(port_b),
    .imm(imm),
    .pc(pc),
    .rd(rd),
    .prediction(prediction),
    .res(brj_res.unit)
  );

  multiply_unit i_multiply_unit (
    .CLK(CLK),
    .nRST(nRST),
    .flush(flush),
    .start(mul_start),
    .port_a(port_a),
    .port_b(port_b),
    .rd(rd),
    .busy(mul_busy),
    .res(mul_res.unit)
  );

  // Issue acceptance is decided next to the occupancy count
  result_queue i_result_queue (
    .CLK(CLK),
    .nRST(nRST),
    .flush(flush),
    .credit_return(credit_return),
    .issue_valid(issue_valid),
    .issue_unit(issue_unit),
    .mul_busy(mul_busy),
    .alu_in(alu_res.queue),
    .brj_in(brj_res.queue),
    .mul_in(mul_res.queue),
    .issue_ready(issue_ready),
    .issue_fire(issue_fire),
    .mul_start(mul_start),
    .res_valid(res_valid),
    .res_wen(res_wen),
    .res_redirect(res_redirect),
    .res_rd(res_rd),
    .res_wdata(res_wdata),
    .res_target(res_target)
  );

endmodule

// ==== rtl/result_queue.sv ====
/*
  Result queue
  In-order FIFO between the functional units and commit. Takes up to
  two results per cycle (multiply first), sends one per cycle under
  credit flow control, and decides whether dispatch may issue
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module result_queue (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic credit_return,
  input logic issue_valid,
  input ooo_exec_pkg::unit_sel_t issue_unit,
  input logic mul_busy,
  unit_result_if.queue alu_in,
  unit_result_if.queue brj_in,
  unit_result_if.queue mul_in,
  output logic issue_ready,
  output logic issue_fire,
  output logic mul_start,
  output logic res_valid,
  output logic res_wen,
  output logic res_redirect,
  output ooo_exec_pkg::reg_idx_t res_rd,
  output ooo_exec_pkg::word_t res_wdata,
  output ooo_exec_pkg::word_t res_target
);
  import ooo_exec_pkg::*;

  // Depth is a power of two, pointers wrap naturally
  localparam int PTR_W = $clog2(`OOO_RQ_DEPTH);
  localparam int CNT_W = $clog2(`OOO_RQ_DEPTH + 1);

  typedef struct packed {
    logic wen;
    reg_idx_t rd;
    word_t wdata;
    logic redirect;
    word_t target;
  } entry_t;

  entry_t mem [`OOO_RQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  credit_t credit_cnt;
  entry_t mul_entry;
  entry_t unit_entry;
  entry_t head;
  logic mul_push;
  logic unit_push;
  logic pop;
  logic free_two;

  // Room for one ALU/BRJ result plus a finishing multiply
  assign free_two = (count <= CNT_W'(`OOO_RQ_DEPTH - 2));
  assign issue_ready = free_two && !(mul_busy && issue_unit == MUL);
  assign issue_fire = issue_valid && issue_ready;
  assign mul_start = issue_fire && (issue_unit == MUL);

  assign mul_push = mul_in.valid;
  // Only one of ALU and BRJ can finish per cycle
  assign unit_push = alu_in.valid || brj_in.valid;

  assign mul_entry = '{mul_in.wen, mul_in.rd, mul_in.wdata, mul_in.redirect, mul_in.target};
  assign unit_entry = alu_in.valid ?
      '{alu_in.wen, alu_in.rd, alu_in.wdata, alu_in.redirect, alu_in.target} :
      '{brj_in.wen, brj_in.rd, brj_in.wdata, brj_in.redirect, brj_in.target};

  // Empty queue bypasses the incoming result straight to the output
  assign head = (count != '0) ? mem[rd_ptr] : (mul_push ? mul_entry : unit_entry);
  assign pop = !flush && (credit_cnt != '0) && ((count != '0) || mul_push || unit_push);

  always_ff @(posedge CLK) begin
    if (mul_push) begin
      mem[wr_ptr] <= mul_entry;
    end
    if (unit_push) begin
      mem[wr_ptr + PTR_W'(mul_push)] <= unit_entry;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_cnt <= credit_t'(`OOO_CREDITS);
      res_valid <= 1'b0;
    end else begin
      if (flush) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count <= '0;
      end else begin
        wr_ptr <= wr_ptr + PTR_W'(mul_push) + PTR_W'(unit_push);
        rd_ptr <= rd_ptr + PTR_W'(pop);
        count <= count + CNT_W'(mul_push) + CNT_W'(unit_push) - CNT_W'(pop);
      end
      // Returns still count during a flush
      credit_cnt <= credit_cnt + credit_t'(credit_return) - credit_t'(pop);
      res_valid <= pop;
    end
  end

  // Registered output towards commit
  always_ff @(posedge CLK) begin
    if (pop) begin
      res_wen <= head.wen;
      res_rd <= head.rd;
      res_wdata <= head.wdata;
      res_redirect <= head.redirect;
      res_target <= head.target;
    end
  end

endmodule

// ==== rtl/multiply_unit.sv ====
/*
  Multiply unit
  Iterative unsigned shift-add multiplier returning the low word;
  one partial product per cycle, busy from start until the result
  has been handed to the result queue
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module multiply_unit (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic start,
  input ooo_exec_pkg::word_t port_a,
  input ooo_exec_pkg::word_t port_b,
  input ooo_exec_pkg::reg_idx_t rd,
  output logic busy,
  unit_result_if.unit res
);
  import ooo_exec_pkg::*;

  localparam int STEP_W = $clog2(`OOO_MUL_STEPS);

  mul_state_t state;
  logic [STEP_W-1:0] step;
  word_t mcand;
  word_t mplier;
  word_t acc;
  reg_idx_t rd_q;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      step <= '0;
    end else if (flush) begin
      // Abort, the partial product is simply dropped
      state <= IDLE;
      step <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= RUN;
            step <= '0;
          end
        end
        RUN: begin
          step <= step + 1'b1;
          if (step == STEP_W'(`OOO_MUL_STEPS - 1)) begin
            state <= DONE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Datapath
  always_ff @(posedge CLK) begin
    if (state == IDLE && start) begin
      mcand <= port_a;
      mplier <= port_b;
      acc <= '0;
      rd_q <= rd;
    end else if (state == RUN) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign busy = (state != IDLE);

  // Result is offered during the single DONE cycle
  assign res.valid = (state == DONE);
  assign res.wen = (rd_q != '0);
  assign res.rd = rd_q;
  assign res.wdata = acc;
  assign res.redirect = 1'b0;
  assign res.target = '0;

endmodule

// ==== rtl/branch_jump_unit.sv ====
/*
  Branch and jump unit
  Resolves branch conditions, computes targets and link values, and
  flags a mispredict against the prediction made at fetch
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module branch_jump_unit (
  input logic issue_valid,
  input ooo_exec_pkg::unit_sel_t issue_unit,
  input ooo_exec_pkg::br_type_t br_type,
  input ooo_exec_pkg::word_t port_a,
  input ooo_exec_pkg::word_t port_b,
  input ooo_exec_pkg::word_t imm,
  input ooo_exec_pkg::word_t pc,
  input ooo_exec_pkg::reg_idx_t rd,
  input logic prediction,
  unit_result_if.unit res
);
  import ooo_exec_pkg::*;

  logic taken;
  logic is_jump;
  word_t pc4;
  word_t target;

  assign pc4 = pc + `OOO_XLEN'(4);
  assign is_jump = (br_type == BR_JAL) || (br_type == BR_JALR);

  always_comb begin
    case (br_type)
      BR_BEQ:  taken = (port_a == port_b);
      BR_BNE:  taken = (port_a != port_b);
      BR_BLT:  taken = ($signed(port_a) < $signed(port_b));
      BR_BGE:  taken = ($signed(port_a) >= $signed(port_b));
      BR_BLTU: taken = (port_a < port_b);
      BR_BGEU: taken = (port_a >= port_b);
      default: taken = 1'b1;
    endcase
  end

  // jalr is register relative with bit 0 cleared
  assign target = (br_type == BR_JALR) ? ((port_a + imm) & ~word_t'(1)) : (pc + imm);

  assign res.valid = issue_valid && (issue_unit == BRJ);
  assign res.wen = is_jump && (rd != '0);
  assign res.rd = rd;
  // Link value, only written for jumps
  assign res.wdata = pc4;
  assign res.redirect = prediction ^ taken;
  assign res.target = taken ? target : pc4;

endmodule

// ==== rtl/arith_unit.sv ====
/*
  Arithmetic unit
  Single-cycle ALU for register and immediate operations; the result
  enters the result queue at the same edge the operation is accepted
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

module arith_unit (
  input logic issue_valid,
  input ooo_exec_pkg::unit_sel_t issue_unit,
  input ooo_exec_pkg::alu_op_t alu_op,
  input ooo_exec_pkg::word_t port_a,
  input ooo_exec_pkg::word_t port_b,
  input ooo_exec_pkg::reg_idx_t rd,
  unit_result_if.unit res
);
  import ooo_exec_pkg::*;

  localparam int SHAMT_W = $clog2(`OOO_XLEN);

  logic [SHAMT_W-1:0] shamt;
  word_t result;

  assign shamt = port_b[SHAMT_W-1:0];

  always_comb begin
    case (alu_op)
      ALU_ADD:  result = port_a + port_b;
      ALU_SUB:  result = port_a - port_b;
      ALU_AND:  result = port_a & port_b;
      ALU_OR:   result = port_a | port_b;
      ALU_XOR:  result = port_a ^ port_b;
      ALU_SLL:  result = port_a << shamt;
      ALU_SRL:  result = port_a >> shamt;
      ALU_SRA:  result = word_t'($signed(port_a) >>> shamt);
      ALU_SLT:  result = word_t'($signed(port_a) < $signed(port_b));
      ALU_SLTU: result = word_t'(port_a < port_b);
      default:  result = '0;
    endcase
  end

  // issue_valid is already qualified by issue_ready
  assign res.valid = issue_valid && (issue_unit == ALU);
  // x0 is never written
  assign res.wen = (rd != '0);
  assign res.rd = rd;
  assign res.wdata = result;
  assign res.redirect = 1'b0;
  assign res.target = '0;

endmodule

// ==== rtl/unit_result_if.sv ====
/*
  Functional unit result
  One unit's finished result on its way into the result queue,
  valid for exactly one cycle per result
*/
`timescale 1ns/100ps
`include "ooo_exec_params.svh"

interface unit_result_if;
  import ooo_exec_pkg::*;

  logic valid;
  logic wen;
  reg_idx_t rd;
  word_t wdata;
  // Mispredict flag and resolved address, branch unit only
  logic redirect;
  word_t target;

  modport unit (
    output valid, wen, rd, wdata, redirect, target
  );

  modport queue (
    input valid, wen, rd, wdata, redirect, target
  );

endinterface

// ==== rtl/ooo_exec_pkg.sv ====
/*
  Execute stage types
  Width typedefs, operation encodings and the multiplier state
*/
`include "ooo_exec_params.svh"

package ooo_exec_pkg;

  typedef logic [`OOO_XLEN-1:0] word_t;
  typedef logic [`OOO_REG_W-1:0] reg_idx_t;
  // Must hold the full grant of OOO_CREDITS
  typedef logic [$clog2(`OOO_CREDITS+1)-1:0] credit_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_t;

  typedef enum logic [2:0] {
    BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
    BR_JAL, BR_JALR
  } br_type_t;

  // Unit that takes the issued operation
  typedef enum logic [1:0] {
    NONE, ALU, BRJ, MUL
  } unit_sel_t;

  typedef enum logic [1:0] {
    IDLE, RUN, DONE
  } mul_state_t;

endpackage

// ==== rtl/ooo_exec_params.svh ====
/*
  Execute stage parameters
  Data and register widths, result queue depth, commit credits and
  the number of multiply iterations
*/
`ifndef OOO_EXEC_PARAMS_SVH
`define OOO_EXEC_PARAMS_SVH

// Data word and register index widths
`define OOO_XLEN 32
`define OOO_REG_W 5

// Result queue entries and credits granted by commit after reset
`define OOO_RQ_DEPTH 4
`define OOO_CREDITS 4

// One partial product per iteration
`define OOO_MUL_STEPS 32

`endif
